//--- logic/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

	// --------------------
	// chip commands, {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		cmd_inhibit      = 4'b1111,
		cmd_nop          = 4'b0111,
		cmd_active       = 4'b0011,
		cmd_read         = 4'b0101,
		cmd_write        = 4'b0100,
		cmd_burst_term   = 4'b0110,
		cmd_precharge    = 4'b0010,
		cmd_auto_refresh = 4'b0001,
		cmd_load_mode    = 4'b0000
	} sdram_cmd_e;

	// --------------------
	// timing
	localparam logic [2:0] cas_latency = 3'd2;	// CL2 below 100 MHz
	localparam logic [2:0] rascas_delay = 3'd2;	// trcd in clocks
	localparam logic [4:0] init_wait_frames = 5'd31;	// power-up frames, count down
	localparam logic [10:0] refresh_default = 11'd842;	// 7.8 us at 108 MHz

	// no write burst, standard op, CL2, sequential, burst of one
	localparam logic [12:0] mode_word = {3'b000, 1'b1, 2'b00, cas_latency, 1'b0, 3'b000};

	// chip word address, flat or split
	typedef struct packed {
		logic [1:0]  bank;
		logic [12:0] row;
		logic [8:0]  col;
	} sdram_field_t;

	typedef union packed {
		logic [23:0]  flat;	// written by the arbiters
		sdram_field_t f;	// read by the scheduler
	} sdram_addr_u;

	// chip pins except dq
	typedef struct packed {
		sdram_cmd_e  cmd;
		logic [12:0] a;
		logic [1:0]  ba;
		logic [1:0]  dqm;	// high = byte masked
	} sdram_pins_t;

	// idle bus: nop, both bytes masked
	localparam sdram_pins_t pins_idle = '{cmd: cmd_nop, a: 13'd0, ba: 2'd0, dqm: 2'b11};

endpackage

`default_nettype wire

//--- logic/client_pkg.sv
`default_nettype none

package client_pkg;

	// toggle handshake port, pending while req != ack
	typedef struct packed {
		logic        req;
		logic        we;
		logic [22:0] a;	// low bank bit, row, col
		logic [1:0]  ds;	// byte enables, [1] = upper byte
		logic [15:0] d;
	} req_port_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] q;
	} req_resp_t;

	typedef logic [22:0] poll_port_t;	// same layout as req_port_t.a

	// what an arbiter offers the scheduler each cycle
	typedef struct packed {
		logic                   valid;
		logic                   is_req;	// else polled fetch
		logic                   we;
		sdram_pkg::sdram_addr_u addr;
		logic [1:0]             ds;
		logic [15:0]            d;
	} grant_t;

	// --------------------
	// frame slots, 8 per frame
	localparam logic [2:0] slot_ras0 = 3'd0;
	localparam logic [2:0] slot_cas0 = slot_ras0 + sdram_pkg::rascas_delay + 3'd1;	// 3
	localparam logic [2:0] slot_read0 = slot_cas0 + sdram_pkg::cas_latency + 3'd2;	// 7
	localparam logic [2:0] slot_ras1 = 3'd4;	// trrd after ras0
	localparam logic [2:0] slot_cas1 = slot_ras1 + sdram_pkg::rascas_delay;	// 6
	localparam logic [2:0] slot_read1 = slot_cas1 + sdram_pkg::cas_latency + 3'd2;	// 2, wraps

endpackage

`default_nettype wire

//--- logic/sdram_init_seq.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_init_seq (
	input  wire                    clk,
	input  wire                    init_n,
	input  wire                    frame_end,	// last slot of frame
	output logic                   init_busy,
	output sdram_pkg::sdram_pins_t init_pins	// valid in slot 0 only
);

	logic [4:0] frame_cnt;	// frames left before normal operation
	logic [4:0] cnt_next;

	assign cnt_next = frame_cnt - 5'd1;
	assign init_busy = frame_cnt != 5'd0;

	// power-up steps land in slot 0 of the new frame
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			frame_cnt <= sdram_pkg::init_wait_frames;
			init_pins <= sdram_pkg::pins_idle;
		end else begin
			init_pins <= sdram_pkg::pins_idle;	// one cycle wide
			if (frame_end && init_busy) begin
				frame_cnt <= cnt_next;
				case (cnt_next)
					5'd15: begin
						init_pins.cmd <= sdram_pkg::cmd_precharge;
						init_pins.a[10] <= 1'b1;	// all banks
					end
					5'd10, 5'd8: init_pins.cmd <= sdram_pkg::cmd_auto_refresh;
					5'd2: begin
						init_pins.cmd <= sdram_pkg::cmd_load_mode;
						init_pins.a <= sdram_pkg::mode_word;
						init_pins.ba <= 2'b00;
					end
					default: ;	// wait frames
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/sdram_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_cfg_regs (
	input  wire        clk,
	input  wire        init_n,
	input  wire        cfg_req,	// four-phase request
	input  wire [10:0] cfg_interval,	// refresh period in clocks
	output logic       cfg_ack,
	input  wire        refresh_taken,	// pulse from scheduler
	output logic       refresh_due
);

	logic [10:0] interval;	// active refresh period
	logic [10:0] since;	// clocks since the last refresh

	// --------------------
	// config handshake
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			cfg_ack <= 1'b0;
			interval <= sdram_pkg::refresh_default;
		end else begin
			if (cfg_req && !cfg_ack) begin
				cfg_ack <= 1'b1;
				interval <= cfg_interval;	// latched as ack rises
			end else if (!cfg_req && cfg_ack) begin
				cfg_ack <= 1'b0;	// return to zero
			end
		end
	end

	// --------------------
	// refresh timer
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			since <= 11'd0;
		end else if (refresh_taken) begin
			since <= 11'd1;	// issue cycle counts as one
		end else if (since != 11'h7ff) begin
			since <= since + 11'd1;	// saturate
		end
	end

	// due as soon as the period is used up, so a slot 4
	// landing exactly on it still gets the refresh
	assign refresh_due = since >= interval;

endmodule

`default_nettype wire

//--- logic/bank_group_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_group_arbiter #(
	parameter int group = 0	// high bank bit, 0 = banks 0-1
) (
	input  wire                    clk,
	input  wire                    init_n,
	input  wire client_pkg::req_port_t  rq,
	output client_pkg::req_resp_t  rs,
	input  wire client_pkg::poll_port_t poll_addr,
	output logic [15:0]            poll_q,
	output client_pkg::grant_t     grant,
	input  wire                    take,	// pulse in this group's ras slot
	input  wire                    rd_done,
	input  wire                    rd_is_req,
	input  wire [15:0]             rd_data,
	input  wire                    wr_done
);

	logic                   req_seen;	// req level when taken
	client_pkg::poll_port_t poll_last;	// last polled address fetched
	logic                   req_pend;
	logic                   poll_pend;
	logic [22:0]            sel_a;
	logic                   ack_r;
	logic [15:0]            q_r;

	assign req_pend = rq.req != req_seen;	// new toggle not yet taken
	assign poll_pend = poll_addr != poll_last;

	// request beats the polled port
	always_comb begin
		grant = '0;
		sel_a = poll_addr;
		if (req_pend) begin
			grant.is_req = 1'b1;
			grant.we = rq.we;
			grant.ds = rq.ds;
			grant.d = rq.d;
			sel_a = rq.a;
		end else begin
			grant.ds = 2'b11;	// polled read, whole word
		end
		grant.valid = req_pend | poll_pend;
		grant.addr.flat = {1'(group), sel_a};	// group picks the bank pair
	end

	// --------------------
	// take and completion
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			req_seen <= 1'b0;
			poll_last <= '0;
			ack_r <= 1'b0;
		end else begin
			if (take) begin
				if (grant.is_req)
					req_seen <= rq.req;
				else
					poll_last <= poll_addr;
			end
			if (wr_done || (rd_done && rd_is_req))
				ack_r <= req_seen;	// closes the toggle
		end
	end

	always_ff @(posedge clk) begin
		if (rd_done && rd_is_req)
			q_r <= rd_data;
		if (rd_done && !rd_is_req)
			poll_q <= rd_data;
	end

	assign rs = '{ack: ack_r, q: q_r};

endmodule

`default_nettype wire

//--- logic/sdram_slot_sched.sv
`timescale 1ns/1ps
`default_nettype none

// frame of 8 slots, two bank groups interleaved
//  slot  issued     returned
//   0    ras0
//   2               data1 (prev frame)
//   3    cas0
//   4    ras1 / refresh
//   6    cas1
//   7               data0
module sdram_slot_sched (
	input  wire                         clk,
	input  wire                         init_n,
	input  wire                         init_busy,
	input  wire sdram_pkg::sdram_pins_t init_pins,
	input  wire client_pkg::grant_t     grant0,
	input  wire client_pkg::grant_t     grant1,
	output logic                        take0,
	output logic                        take1,
	output logic                        rd_done0,
	output logic                        rd_done1,
	output logic                        rd_is_req0,
	output logic                        rd_is_req1,
	output logic                        wr_done0,
	output logic                        wr_done1,
	output logic [15:0]                 rd_data,	// dq registered every cycle
	output logic                        frame_end,
	input  wire                         refresh_due,
	output logic                        refresh_taken,
	output sdram_pkg::sdram_pins_t      pins,
	inout  wire [15:0]                  dq
);

	logic [2:0]         slot;
	client_pkg::grant_t lat0;	// group 0 access in flight
	client_pkg::grant_t lat1;
	logic               busy0;	// group 0 has an access this frame
	logic               busy1;	// group 1, held until next ras1
	logic               refresh_hold;	// banks busy refreshing, skip next ras0
	logic               refresh_go;
	logic               cas0_go;
	logic               cas1_go;
	logic [15:0]        dq_out;
	logic               dq_oe;

	// --------------------
	// command builders
	function automatic sdram_pkg::sdram_pins_t row_open(sdram_pkg::sdram_addr_u ad);
		sdram_pkg::sdram_pins_t p;
		p = sdram_pkg::pins_idle;
		p.cmd = sdram_pkg::cmd_active;
		p.a = ad.f.row;
		p.ba = ad.f.bank;
		return p;
	endfunction

	function automatic sdram_pkg::sdram_pins_t col_access(client_pkg::grant_t g);
		sdram_pkg::sdram_pins_t p;
		p.cmd = g.we ? sdram_pkg::cmd_write : sdram_pkg::cmd_read;
		p.a = {3'b001, 1'b0, g.addr.f.col};	// a10 high, auto precharge
		p.ba = g.addr.f.bank;
		p.dqm = ~g.ds;	// ds is enable, dqm is mask
		return p;
	endfunction

	// --------------------
	// slot decode
	assign frame_end = slot == 3'd7;

	assign take0 = !init_busy && slot == client_pkg::slot_ras0 && grant0.valid &&
		!refresh_hold;
	assign take1 = !init_busy && slot == client_pkg::slot_ras1 && grant1.valid;

	// refresh only when both groups leave the frame free
	assign refresh_go = !init_busy && slot == client_pkg::slot_ras1 && !grant1.valid &&
		!busy0 && refresh_due;
	assign refresh_taken = refresh_go;

	assign cas0_go = slot == client_pkg::slot_cas0 && busy0;
	assign cas1_go = slot == client_pkg::slot_cas1 && busy1;

	assign wr_done0 = cas0_go && lat0.we;	// write acks with its cas
	assign wr_done1 = cas1_go && lat1.we;
	assign rd_done0 = slot == client_pkg::slot_read0 && busy0 && !lat0.we;
	assign rd_done1 = slot == client_pkg::slot_read1 && busy1 && !lat1.we;
	assign rd_is_req0 = lat0.is_req;
	assign rd_is_req1 = lat1.is_req;

	assign dq = dq_oe ? dq_out : 16'bz;	// released unless writing

	// --------------------
	// command bus
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			slot <= 3'd0;
			busy0 <= 1'b0;
			busy1 <= 1'b0;
			refresh_hold <= 1'b0;
			pins <= sdram_pkg::pins_idle;
			dq_oe <= 1'b0;
		end else begin
			slot <= slot + 3'd1;	// wraps at 8
			pins <= sdram_pkg::pins_idle;	// nop by default
			dq_oe <= 1'b0;

			if (slot == client_pkg::slot_ras0) begin
				busy0 <= take0;
				refresh_hold <= 1'b0;
				if (take0)
					pins <= row_open(grant0.addr);
			end

			if (slot == client_pkg::slot_ras1) begin
				busy1 <= take1;
				if (take1)
					pins <= row_open(grant1.addr);
				if (refresh_go) begin
					pins.cmd <= sdram_pkg::cmd_auto_refresh;
					refresh_hold <= 1'b1;
				end
			end

			if (cas0_go) begin
				pins <= col_access(lat0);
				dq_oe <= lat0.we;
			end

			if (cas1_go) begin
				pins <= col_access(lat1);
				dq_oe <= lat1.we;
			end

			// power-up steps own the bus until done
			if (init_busy)
				pins <= init_pins;
		end
	end

	// --------------------
	// payload
	always_ff @(posedge clk) begin
		rd_data <= dq;	// CL2 word shows up here in the read slot
		if (take0)
			lat0 <= grant0;
		if (take1)
			lat1 <= grant1;
		if (slot == client_pkg::slot_cas0)
			dq_out <= lat0.d;	// aligned with the write command
		if (slot == client_pkg::slot_cas1)
			dq_out <= lat1.d;
	end

endmodule

`default_nettype wire

//--- logic/sdram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top (
	input  wire                         clk,
	input  wire                         init_n,
	input  wire client_pkg::req_port_t  rq0,	// banks 0-1
	input  wire client_pkg::req_port_t  rq1,	// banks 2-3
	output client_pkg::req_resp_t       rs0,
	output client_pkg::req_resp_t       rs1,
	input  wire client_pkg::poll_port_t poll0,
	input  wire client_pkg::poll_port_t poll1,
	output logic [15:0]                 poll_q0,
	output logic [15:0]                 poll_q1,
	input  wire                         cfg_req,
	input  wire [10:0]                  cfg_interval,
	output logic                        cfg_ack,
	output sdram_pkg::sdram_pins_t      sdram,
	inout  wire [15:0]                  sdram_dq
);

	logic                   frame_end;
	logic                   init_busy;
	sdram_pkg::sdram_pins_t init_pins;
	logic                   refresh_due;
	logic                   refresh_taken;
	client_pkg::grant_t     grant0;
	client_pkg::grant_t     grant1;
	logic                   take0;
	logic                   take1;
	logic                   rd_done0;
	logic                   rd_done1;
	logic                   rd_is_req0;
	logic                   rd_is_req1;
	logic                   wr_done0;
	logic                   wr_done1;
	logic [15:0]            rd_data;	// shared, groups use different slots

	sdram_init_seq u_init (
		.clk       (clk),
		.init_n    (init_n),
		.frame_end (frame_end),
		.init_busy (init_busy),
		.init_pins (init_pins)
	);

	sdram_cfg_regs u_cfg (
		.clk           (clk),
		.init_n        (init_n),
		.cfg_req       (cfg_req),
		.cfg_interval  (cfg_interval),
		.cfg_ack       (cfg_ack),
		.refresh_taken (refresh_taken),
		.refresh_due   (refresh_due)
	);

	// --------------------
	// one arbiter per bank pair
	bank_group_arbiter #(.group(0)) u_arb0 (
		.clk       (clk),
		.init_n    (init_n),
		.rq        (rq0),
		.rs        (rs0),
		.poll_addr (poll0),
		.poll_q    (poll_q0),
		.grant     (grant0),
		.take      (take0),
		.rd_done   (rd_done0),
		.rd_is_req (rd_is_req0),
		.rd_data   (rd_data),
		.wr_done   (wr_done0)
	);

	bank_group_arbiter #(.group(1)) u_arb1 (
		.clk       (clk),
		.init_n    (init_n),
		.rq        (rq1),
		.rs        (rs1),
		.poll_addr (poll1),
		.poll_q    (poll_q1),
		.grant     (grant1),
		.take      (take1),
		.rd_done   (rd_done1),
		.rd_is_req (rd_is_req1),
		.rd_data   (rd_data),
		.wr_done   (wr_done1)
	);

	sdram_slot_sched u_sched (
		.clk           (clk),
		.init_n        (init_n),
		.init_busy     (init_busy),
		.init_pins     (init_pins),
		.grant0        (grant0),
		.grant1        (grant1),
		.take0         (take0),
		.take1         (take1),
		.rd_done0      (rd_done0),
		.rd_done1      (rd_done1),
		.rd_is_req0    (rd_is_req0),
		.rd_is_req1    (rd_is_req1),
		.wr_done0      (wr_done0),
		.wr_done1      (wr_done1),
		.rd_data       (rd_data),
		.frame_end     (frame_end),
		.refresh_due   (refresh_due),
		.refresh_taken (refresh_taken),
		.pins          (sdram),
		.dq            (sdram_dq)
	);

endmodule

`default_nettype wire

//--- bench/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
	input  wire                         clk,
	input  wire                         init_n,
	input  wire sdram_pkg::sdram_pins_t pins,
	inout  wire [15:0]                  dq,
	output logic                        fault,	// sticky, any illegal command
	output int                          refresh_cnt,
	output logic                        mode_ok
);

	logic [15:0] mem [logic [23:0]];	// sparse, only touched words
	logic [12:0] open_row [4];
	logic [3:0]  row_open;
	logic        precharged;
	logic [2:0]  phase;	// mirrors the controller frame slot
	logic        rd_v;	// read seen last edge
	logic [15:0] rd_word;
	logic        dq_oe;
	logic [15:0] dq_o;
	logic [23:0] acc;
	logic [15:0] w;

	assign dq = dq_oe ? dq_o : 16'bz;

	// untouched words read back as a pattern of the whole address
	function automatic logic [15:0] fill_word(logic [23:0] a);
		return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h3c5a;
	endfunction

	function automatic logic [15:0] peek(logic [23:0] a);
		return mem.exists(a) ? mem[a] : fill_word(a);
	endfunction

	task automatic report_violation(input string what);
		$display("sdram model: %s at %0t", what, $time);
		fault <= 1'b1;
	endtask

	// --------------------
	// command decoder
	always @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			fault <= 1'b0;
			refresh_cnt <= 0;
			mode_ok <= 1'b0;
			precharged <= 1'b0;
			row_open <= 4'b0;
			phase <= 3'd0;
			rd_v <= 1'b0;
			dq_oe <= 1'b0;
		end else begin
			phase <= phase + 3'd1;
			dq_oe <= rd_v;	// CL2, data one edge after the pipe stage
			dq_o <= rd_word;
			rd_v <= 1'b0;
			acc = {pins.ba, open_row[pins.ba], pins.a[8:0]};
			case (pins.cmd)
				sdram_pkg::cmd_active: begin
					if (!mode_ok)
						report_violation("ACTIVE before mode load");
					if (row_open[pins.ba])
						report_violation("ACTIVE on open bank");
					// group 0 row opens show in slot 1, group 1 in slot 5
					if (phase == 3'd1 && pins.ba[1])
						report_violation("group 0 reached banks 2-3");
					else if (phase == 3'd5 && !pins.ba[1])
						report_violation("group 1 reached banks 0-1");
					else if (phase != 3'd1 && phase != 3'd5)
						report_violation("ACTIVE off slot");
					row_open[pins.ba] <= 1'b1;
					open_row[pins.ba] <= pins.a;
				end
				sdram_pkg::cmd_read: begin
					if (!row_open[pins.ba])
						report_violation("READ on closed bank");
					rd_v <= 1'b1;
					rd_word <= peek(acc);
					if (pins.a[10])
						row_open[pins.ba] <= 1'b0;	// auto precharge
				end
				sdram_pkg::cmd_write: begin
					if (!row_open[pins.ba])
						report_violation("WRITE on closed bank");
					w = peek(acc);
					if (!pins.dqm[0])
						w[7:0] = dq[7:0];
					if (!pins.dqm[1])
						w[15:8] = dq[15:8];
					mem[acc] = w;
					if (pins.a[10])
						row_open[pins.ba] <= 1'b0;
				end
				sdram_pkg::cmd_precharge: begin
					if (pins.a[10])
						row_open <= 4'b0;
					else
						row_open[pins.ba] <= 1'b0;
					precharged <= 1'b1;
				end
				sdram_pkg::cmd_auto_refresh: begin
					if (row_open != 4'b0)
						report_violation("refresh with open row");
					refresh_cnt <= refresh_cnt + 1;
				end
				sdram_pkg::cmd_load_mode: begin
					// CL2, burst 1, sequential, single writes
					if (!precharged || refresh_cnt < 2 || pins.a != 13'h220)
						report_violation("bad mode load");
					mode_ok <= 1'b1;
				end
				default: ;	// nop, inhibit
			endcase
		end
	end

endmodule

`default_nettype wire

//--- bench/sdram_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_asserts (
	input wire                         clk,
	input wire                         init_n,
	input wire                         init_busy,
	input wire [2:0]                   slot,
	input wire sdram_pkg::sdram_pins_t pins,
	input wire                         dq_oe
);

	int fail_cnt = 0;	// failed checks so far

	// power-up owns the bus so no row opens
	no_active_in_init: assert property (@(posedge clk) disable iff (!init_n)
		$past(init_busy) |-> pins.cmd != sdram_pkg::cmd_active)
		else begin
			fail_cnt++;
			$error("ACTIVE during power-up");
		end

	// column commands come from the cas slots only
	cas_in_slot: assert property (@(posedge clk) disable iff (!init_n)
		(pins.cmd == sdram_pkg::cmd_read || pins.cmd == sdram_pkg::cmd_write) |->
		($past(slot) == 3'd3 || $past(slot) == 3'd6))
		else begin
			fail_cnt++;
			$error("column command off slot");
		end

	dq_only_on_write: assert property (@(posedge clk) disable iff (!init_n)
		dq_oe |-> pins.cmd == sdram_pkg::cmd_write)
		else begin
			fail_cnt++;
			$error("dq driven outside write");
		end

endmodule

`default_nettype wire

//--- bench/tb_sdram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram;

	localparam int rounds = 12;
	// early write, 6 per round, 16 half-word ops, 2 polls
	localparam int num_ops = 1 + 6 * rounds + 16 + 2;
	localparam int idle_cycles = 4000;
	localparam int watchdog_cycles = num_ops * 20 + 300 + idle_cycles;

	logic                   clk = 1'b0;
	logic                   init_n;
	client_pkg::req_port_t  rq0;
	client_pkg::req_port_t  rq1;
	client_pkg::req_resp_t  rs0;
	client_pkg::req_resp_t  rs1;
	client_pkg::poll_port_t poll0;
	client_pkg::poll_port_t poll1;
	logic [15:0]            poll_q0;
	logic [15:0]            poll_q1;
	logic                   cfg_req;
	logic [10:0]            cfg_interval;
	logic                   cfg_ack;
	sdram_pkg::sdram_pins_t sdram;
	wire  [15:0]            sdram_dq;
	logic                   model_fault;
	int                     refresh_cnt;
	logic                   mode_ok;

	int unsigned  lcg_state = 52;
	logic [15:0]  shadow [logic [23:0]];	// expected chip contents
	logic [22:0]  written0 [$];
	logic [22:0]  written1 [$];

	always #5 clk = ~clk;

	sdram_ctrl_top dut0 (
		.clk (clk), .init_n (init_n),
		.rq0 (rq0), .rq1 (rq1), .rs0 (rs0), .rs1 (rs1),
		.poll0 (poll0), .poll1 (poll1), .poll_q0 (poll_q0), .poll_q1 (poll_q1),
		.cfg_req (cfg_req), .cfg_interval (cfg_interval), .cfg_ack (cfg_ack),
		.sdram (sdram), .sdram_dq (sdram_dq)
	);

	sdram_model u_chip (
		.clk (clk), .init_n (init_n), .pins (sdram), .dq (sdram_dq),
		.fault (model_fault), .refresh_cnt (refresh_cnt), .mode_ok (mode_ok)
	);

	bind sdram_slot_sched sdram_asserts u_chk (
		.clk (clk), .init_n (init_n), .init_busy (init_busy),
		.slot (slot), .pins (pins), .dq_oe (dq_oe)
	);

	// --------------------
	// reference model
	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [15:0] fill_word(logic [23:0] a);
		return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h3c5a;
	endfunction

	function automatic logic [15:0] ref_read(logic [23:0] a);
		return shadow.exists(a) ? shadow[a] : fill_word(a);
	endfunction

	function automatic void ref_write(logic [23:0] a, logic [1:0] ds, logic [15:0] d);
		logic [15:0] w;
		w = ref_read(a);
		if (ds[0])
			w[7:0] = d[7:0];
		if (ds[1])
			w[15:8] = d[15:8];
		shadow[a] = w;
	endfunction

	// --------------------
	// checks
	task automatic stop_fail();
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic check_resp(input client_pkg::req_resp_t got, input logic exp_ack,
		input logic [15:0] exp_q, input logic use_q, input int g);
		if (got.ack !== exp_ack || (use_q && got.q !== exp_q)) begin
			$display("ERR %0t group %0d ack %b q %h, expected ack %b q %h",
				$time, g, got.ack, got.q, exp_ack, exp_q);
			stop_fail();
		end
	endtask

	task automatic check_poll(input logic [15:0] got, input logic [15:0] exp, input int g);
		if (got !== exp) begin
			$display("ERR %0t poll group %0d got %h expected %h", $time, g, got, exp);
			stop_fail();
		end
	endtask

	task automatic check_refresh(input int got, input int lo, input int hi);
		if (got < lo || got > hi) begin
			$display("ERR %0t refresh count %0d outside %0d..%0d", $time, got, lo, hi);
			stop_fail();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t %s is %b, expected %b", $time, what, got, exp);
			stop_fail();
		end
	endtask

	always @(negedge clk) begin
		if (model_fault === 1'b1) begin
			$display("the memory model saw an illegal command sequence");
			stop_fail();
		end else if (dut0.u_sched.u_chk.fail_cnt != 0) begin
			$display("a check on the chip command bus failed");
			stop_fail();
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired, the run took too long");
		stop_fail();
	end

	// --------------------
	// client drivers
	task automatic drive_slot();
		@(posedge clk);
		#1;
	endtask

	task automatic issue(input int g, input logic we, input logic [22:0] a,
		input logic [1:0] ds, input logic [15:0] d);
		if (g == 0)
			rq0 = '{req: ~rq0.req, we: we, a: a, ds: ds, d: d};
		else
			rq1 = '{req: ~rq1.req, we: we, a: a, ds: ds, d: d};
		if (we)
			ref_write({g[0], a}, ds, d);
	endtask

	task automatic wait_ack(input int g, input int limit);
		int n;
		n = 0;
		forever begin
			@(negedge clk);
			if (g == 0 ? rs0.ack == rq0.req : rs1.ack == rq1.req)
				break;
			n++;
			if (n > limit) begin
				$display("no ack from group %0d within %0d cycles", g, limit);
				stop_fail();
			end
		end
	endtask

	task automatic write_both(input logic [22:0] a0, input logic [22:0] a1,
		input logic [1:0] ds0, input logic [1:0] ds1);
		drive_slot();
		issue(0, 1'b1, a0, ds0, 16'(next_rand() >> 16));
		issue(1, 1'b1, a1, ds1, 16'(next_rand() >> 16));
		wait_ack(0, 40);
		wait_ack(1, 40);
		@(negedge clk);	// ack must hold, no second toggle
		check_resp(rs0, rq0.req, 16'h0, 1'b0, 0);
		check_resp(rs1, rq1.req, 16'h0, 1'b0, 1);
	endtask

	task automatic read_both(input logic [22:0] a0, input logic [22:0] a1);
		drive_slot();
		issue(0, 1'b0, a0, 2'b11, 16'h0);
		issue(1, 1'b0, a1, 2'b11, 16'h0);
		wait_ack(0, 40);
		wait_ack(1, 40);
		@(negedge clk);
		check_resp(rs0, rq0.req, ref_read({1'b0, a0}), 1'b1, 0);
		check_resp(rs1, rq1.req, ref_read({1'b1, a1}), 1'b1, 1);
	endtask

	// --------------------
	// test sequence
	initial begin
		logic [22:0] a0;
		logic [22:0] a1;
		int base;
		init_n = 1'b0;
		rq0 = '0;
		rq1 = '0;
		poll0 = '0;
		poll1 = '0;
		cfg_req = 1'b0;
		cfg_interval = 11'd0;
		repeat (4) @(posedge clk);
		#1 init_n = 1'b1;

		// early request waits out power-up
		a0 = 23'(next_rand() >> 9);
		written0.push_back(a0);
		issue(0, 1'b1, a0, 2'b11, 16'(next_rand() >> 16));
		wait_ack(0, 400);
		check_flag(mode_ok, 1'b1, "mode loaded at first ack");
		@(negedge clk);
		check_resp(rs0, rq0.req, 16'h0, 1'b0, 0);

		for (int i = 0; i < rounds; i++) begin
			a0 = 23'(next_rand() >> 9);
			a1 = 23'(next_rand() >> 9);
			written0.push_back(a0);
			written1.push_back(a1);
			write_both(a0, a1, 2'b11, 2'b11);
			read_both(a0, a1);
			a0 = written0[next_rand() % written0.size()];	// older word
			a1 = written1[next_rand() % written1.size()];
			read_both(a0, a1);
		end

		// half-word writes
		for (int i = 0; i < 2; i++) begin
			a0 = written0[i];
			a1 = written1[i];
			write_both(a0, a1, 2'b01, 2'b10);
			read_both(a0, a1);
			write_both(a0, a1, 2'b10, 2'b01);
			read_both(a0, a1);
		end

		// polled ports
		drive_slot();
		poll0 = written0[3];
		poll1 = written1[5];
		repeat (24) @(posedge clk);
		@(negedge clk);
		check_poll(poll_q0, ref_read({1'b0, poll0}), 0);
		check_poll(poll_q1, ref_read({1'b1, poll1}), 1);

		// config handshake and refresh rate
		drive_slot();
		cfg_interval = 11'd200;
		cfg_req = 1'b1;
		#1;
		check_flag(cfg_ack, 1'b0, "cfg_ack before req seen");
		drive_slot();
		check_flag(cfg_ack, 1'b1, "cfg_ack after req");
		cfg_req = 1'b0;
		drive_slot();
		check_flag(cfg_ack, 1'b0, "cfg_ack after req low");
		base = refresh_cnt;
		repeat (idle_cycles) @(posedge clk);
		#1;
		check_refresh(refresh_cnt - base, idle_cycles / 208, idle_cycles / 200 + 1);

		if (dut0.u_sched.u_chk.fail_cnt == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("a check on the chip command bus failed");
			stop_fail();
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
logic/sdram_pkg.sv
logic/client_pkg.sv
logic/sdram_init_seq.sv
logic/sdram_cfg_regs.sv
logic/bank_group_arbiter.sv
logic/sdram_slot_sched.sv
logic/sdram_ctrl_top.sv
bench/sdram_model.sv
bench/sdram_asserts.sv
bench/tb_sdram.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sdram
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
